// ==== link_pkg.sv ====
`default_nettype none

package link_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int word_width      = 64;
    localparam int lane_width      = 16;
    localparam int lane_count      = 4;
    localparam int lane_idx_width  = $clog2(lane_count) + 1;
    localparam int fifo_depth_log2 = 4;
    localparam int length_width    = 32;

    // command kind code, word bits 58:56
    localparam logic [2:0] kind_tik = 3'd3;

    // ------------------------------------------------------------------------
    // send state machine
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        send_idle  = 3'd0,
        send_data  = 3'd1,
        ready_wait = 3'd2,
        tik_wait   = 3'd3,
        tik_end    = 3'd4
    } send_state_e;

    // one link word, seen either as four lanes or as a command
    typedef union packed {
        // lane 3 at the top, sent first
        logic [lane_count-1:0][lane_width-1:0] lanes;
        struct packed {
            logic [4:0]              rsvd_hi;
            logic [2:0]              kind;
            logic [22:0]             rsvd_lo;
            logic                    end_flag;
            logic [length_width-1:0] length;
        } cmd;
    } link_word_u;

endpackage

`default_nettype wire

// ==== word_fifo.sv ====
`default_nettype none

module word_fifo
    import link_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  wr,
    input  wire [word_width-1:0] wr_word,
    input  wire                  rd,
    output link_word_u           rd_word,
    output logic                 full,
    output logic                 empty
);

    logic [word_width-1:0]    mem [0:(1 << fifo_depth_log2)-1];
    // one extra bit tells full from empty
    logic [fifo_depth_log2:0] wr_ptr;
    logic [fifo_depth_log2:0] rd_ptr;
    logic [fifo_depth_log2:0] fill;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr[fifo_depth_log2-1:0]] <= wr_word;
        end
        if (rd) begin
            rd_word <= mem[rd_ptr[fifo_depth_log2-1:0]];
        end
    end

    assign fill  = wr_ptr - rd_ptr;
    assign full  = (fill == {1'b1, {fifo_depth_log2{1'b0}}});
    assign empty = (fill == '0);

    // writer must honour s_tready, reader must check empty
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rst_n) wr |-> !full
    ) else $error("fifo written while full");

    a_no_read_empty: assert property (
        @(posedge clk) disable iff (!rst_n) rd |-> !empty
    ) else $error("fifo read while empty");

endmodule

`default_nettype wire

// ==== tik_timer.sv ====
`default_nettype none

module tik_timer
    import link_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        tik_load,
    input  wire        load_end,
    input  wire        link_word_u word,
    output logic       tik,
    output logic       busy
);

    logic                    tik_flag;
    logic                    end_flag;
    logic [length_width-1:0] len;
    logic [length_width-1:0] cnt;
    logic                    done;

    assign done = (cnt == len);

    // flag is up for len+1 cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tik_flag <= 1'b0;
            end_flag <= 1'b0;
        end else if (tik_load) begin
            tik_flag <= !load_end;
            end_flag <= load_end;
        end else if (done) begin
            tik_flag <= 1'b0;
            end_flag <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tik_load) begin
            len <= word.cmd.length;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (busy && !done) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    assign busy = tik_flag | end_flag;
    assign tik  = tik_flag;

    // a new command never lands inside a running period
    a_load_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) tik_load |-> !busy
    ) else $error("command loaded during a tik or end period");

endmodule

`default_nettype wire

// ==== lane_serializer.sv ====
`default_nettype none

module lane_serializer
    import link_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire link_word_u      word,
    input  wire                  lane_valid,
    input  wire                  lane_advance,
    input  wire                  lane_clear,
    output logic [lane_width-1:0] lane_data,
    output logic                 lane_par,
    output logic                 last_lane_done
);

    logic [lane_idx_width-1:0] lane_idx;
    logic [lane_idx_width-2:0] lane_pos;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_idx <= '0;
        end else if (lane_clear) begin
            lane_idx <= '0;
        end else if (lane_advance) begin
            lane_idx <= lane_idx + 1'b1;
        end
    end

    // msb lane first, so index 0 picks lane 3
    assign lane_pos       = ~lane_idx[lane_idx_width-2:0];
    assign last_lane_done = (lane_idx == lane_idx_width'(lane_count));

    assign lane_data = last_lane_done ? '0 : word.lanes[lane_pos];

    // even parity, quiet when no lane is offered
    assign lane_par = lane_valid ? ^lane_data : 1'b0;

    a_no_advance_past_end: assert property (
        @(posedge clk) disable iff (!rst_n) lane_advance |-> !last_lane_done
    ) else $error("lane advance after last lane");

    // chip samples the lane at any point while valid is up
    a_lane_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        lane_valid && $past(lane_valid) |-> $stable(lane_data)
    ) else $error("lane data changed while valid");

endmodule

`default_nettype wire

// ==== send_fsm.sv ====
`default_nettype none

module send_fsm
    import link_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             fifo_empty,
    input  wire link_word_u word,
    input  wire             link_ready,
    input  wire             link_err,
    input  wire             timer_busy,
    input  wire             last_lane_done,
    output logic            fifo_rd,
    output logic            lane_valid,
    output logic            lane_advance,
    output logic            lane_clear,
    output logic            tik_load,
    output logic            load_end
);

    send_state_e state;
    send_state_e state_nx;

    logic ready_d;
    logic ready_2d;
    logic err_d;
    logic err_2d;
    logic ready_seen_high;
    logic ready_seen_low;
    logic err_seen_low;
    logic is_cmd;

    // ------------------------------------------------------------------------
    // chip level synchronizer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_d  <= 1'b0;
            ready_2d <= 1'b0;
            err_d    <= 1'b0;
            err_2d   <= 1'b0;
        end else begin
            ready_d  <= link_ready;
            ready_2d <= ready_d;
            err_d    <= link_err;
            err_2d   <= err_d;
        end
    end

    // level only counts when both samples agree
    assign ready_seen_high = ready_d & ready_2d;
    assign ready_seen_low  = !ready_d & !ready_2d;
    assign err_seen_low    = !err_d & !err_2d;

    assign is_cmd = (word.cmd.kind == kind_tik);

    // ------------------------------------------------------------------------
    // send state machine
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= send_idle;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            send_idle: begin
                if (!fifo_empty) begin
                    state_nx = send_data;
                end
            end
            send_data: begin
                if (is_cmd) begin
                    state_nx = word.cmd.end_flag ? tik_end : tik_wait;
                end else if (ready_seen_high) begin
                    state_nx = ready_wait;
                end
            end
            ready_wait: begin
                if (ready_seen_low) begin
                    state_nx = last_lane_done ? send_idle : send_data;
                end
            end
            tik_wait, tik_end: begin
                if (!timer_busy) begin
                    state_nx = send_idle;
                end
            end
            default: state_nx = send_idle;
        endcase
    end

    assign fifo_rd    = (state == send_idle) && !fifo_empty;
    assign lane_valid = (state == send_data) && !is_cmd;

    // err high at acceptance repeats the same lane
    assign lane_advance = lane_valid && ready_seen_high && err_seen_low;
    assign lane_clear   = (state == ready_wait) && (state_nx == send_idle);

    assign tik_load = (state == send_data) && is_cmd;
    assign load_end = tik_load && word.cmd.end_flag;

    a_quiet_during_tik: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(lane_valid) |-> !timer_busy
    ) else $error("lane offered during tik or end period");

endmodule

`default_nettype wire

// ==== chip_link_tx.sv ====
`default_nettype none

module chip_link_tx
    import link_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire [word_width-1:0]  s_tdata,
    input  wire                   s_tvalid,
    output logic                  s_tready,
    output logic                  tik,
    output logic [lane_width-1:0] lane_data,
    output logic                  lane_valid,
    output logic                  lane_par,
    input  wire                   link_ready,
    input  wire                   link_err
);

    logic       fifo_full;
    logic       fifo_empty;
    logic       fifo_rd;
    link_word_u fifo_word;
    logic       lane_advance;
    logic       lane_clear;
    logic       last_lane_done;
    logic       tik_load;
    logic       load_end;
    logic       timer_busy;

    assign s_tready = !fifo_full;

    word_fifo word_fifo_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (s_tvalid && s_tready),
        .wr_word (s_tdata),
        .rd      (fifo_rd),
        .rd_word (fifo_word),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    send_fsm send_fsm_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .fifo_empty     (fifo_empty),
        .word           (fifo_word),
        .link_ready     (link_ready),
        .link_err       (link_err),
        .timer_busy     (timer_busy),
        .last_lane_done (last_lane_done),
        .fifo_rd        (fifo_rd),
        .lane_valid     (lane_valid),
        .lane_advance   (lane_advance),
        .lane_clear     (lane_clear),
        .tik_load       (tik_load),
        .load_end       (load_end)
    );

    tik_timer tik_timer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .tik_load (tik_load),
        .load_end (load_end),
        .word     (fifo_word),
        .tik      (tik),
        .busy     (timer_busy)
    );

    lane_serializer lane_serializer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .word           (fifo_word),
        .lane_valid     (lane_valid),
        .lane_advance   (lane_advance),
        .lane_clear     (lane_clear),
        .lane_data      (lane_data),
        .lane_par       (lane_par),
        .last_lane_done (last_lane_done)
    );

endmodule

`default_nettype wire

// ==== tb_chip_link_tx.sv ====
`default_nettype none

module tb_chip_link_tx
    import link_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles  = 8;
    localparam int lane_wait_max = 200;
    // words sent over all tests plus the tik and end periods
    localparam int test_words      = 3 + 1 + 2 + 2 + 17;
    localparam int tik_cycles      = (5 + 1) + (7 + 1);
    localparam int watchdog_cycles = reset_cycles + 200 * test_words + tik_cycles;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [word_width-1:0] s_tdata;
    logic                  s_tvalid;
    logic                  s_tready;
    logic                  tik;
    logic [lane_width-1:0] lane_data;
    logic                  lane_valid;
    logic                  lane_par;
    logic                  link_ready;
    logic                  link_err;

    // lanes taken by the chip model, in order
    logic [lane_width-1:0] lane_q [$];
    logic                  par_q [$];
    bit                    err_q [$];
    int                    rec_rd = 0;

    integer seed        = 32'hc85d_3354;
    int     pres_idx    = 0;
    int     err_pres    = -1;
    bit     ready_hold  = 1'b0;
    int     error_count = 0;
    int     check_count = 0;

    chip_link_tx chip_link_tx_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .s_tdata    (s_tdata),
        .s_tvalid   (s_tvalid),
        .s_tready   (s_tready),
        .tik        (tik),
        .lane_data  (lane_data),
        .lane_valid (lane_valid),
        .lane_par   (lane_par),
        .link_ready (link_ready),
        .link_err   (link_err)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // chip model
    // ------------------------------------------------------------------------
    initial begin : chip_model
        int                    delay;
        bit                    err_now;
        logic [lane_width-1:0] seen_data;
        logic                  seen_par;
        link_ready = 1'b0;
        link_err   = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && lane_valid && !ready_hold) begin
                delay     = $random(seed) & 3;
                err_now   = (pres_idx == err_pres);
                pres_idx  = pres_idx + 1;
                seen_data = lane_data;
                seen_par  = lane_par;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                link_ready <= 1'b1;
                link_err   <= err_now;
                @(negedge clk);
                // keep the last lane offered before valid falls
                while (lane_valid) begin
                    seen_data = lane_data;
                    seen_par  = lane_par;
                    @(negedge clk);
                end
                lane_q.push_back(seen_data);
                par_q.push_back(seen_par);
                err_q.push_back(err_now);
                @(posedge clk);
                link_ready <= 1'b0;
                link_err   <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("Something failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    task automatic check_bit(input string name, input logic exp, input logic got);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_lane(input logic [lane_width-1:0] exp_data, input logic exp_par,
                              input logic [lane_width-1:0] got_data, input logic got_par);
        check_count++;
        if (got_data !== exp_data) begin
            error_count++;
            $display("error lane_data expected %h got %h", exp_data, got_data);
        end
        if (got_par !== exp_par) begin
            error_count++;
            $display("error lane_par expected %h got %h", exp_par, got_par);
        end
    endtask

    task automatic check_word(input link_word_u exp, input link_word_u got);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error word expected %h got %h", exp, got);
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    // kind field stays 5 and never marks a command
    function automatic link_word_u data_word(input int n);
        data_word = {16'ha5c0 + 16'(n), 16'h3c00 + 16'(n), 16'h0f0f ^ 16'(n),
                     16'h7e00 + 16'(3 * n)};
    endfunction

    function automatic link_word_u cmd_word(input logic [length_width-1:0] len,
                                            input logic is_end);
        cmd_word              = '0;
        cmd_word.cmd.kind     = kind_tik;
        cmd_word.cmd.end_flag = is_end;
        cmd_word.cmd.length   = len;
    endfunction

    task automatic send_word(input link_word_u w);
        bit taken;
        taken = 1'b0;
        @(posedge clk);
        s_tdata  <= w;
        s_tvalid <= 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = s_tready;
            @(posedge clk);
        end
        s_tvalid <= 1'b0;
    endtask

    task automatic pop_lane(output logic [lane_width-1:0] data, output logic par,
                            output bit err, output bit ok);
        int waited;
        waited = 0;
        while (rec_rd >= lane_q.size() && waited < lane_wait_max) begin
            @(negedge clk);
            waited++;
        end
        ok   = (rec_rd < lane_q.size());
        data = '0;
        par  = 1'b0;
        err  = 1'b0;
        if (ok) begin
            data   = lane_q[rec_rd];
            par    = par_q[rec_rd];
            err    = err_q[rec_rd];
            rec_rd = rec_rd + 1;
        end else begin
            error_count++;
            $display("no lane reached the chip within %0d cycles", lane_wait_max);
        end
    endtask

    // pulls lanes until the word is complete
    // lanes taken with err are retries
    task automatic expect_word(input link_word_u sent, input int exp_retries);
        link_word_u            got;
        logic [lane_width-1:0] data;
        logic                  par;
        bit                    err;
        bit                    ok;
        logic [1:0]            pos;
        int                    done_lanes;
        int                    retries;
        got        = '0;
        done_lanes = 0;
        retries    = 0;
        ok         = 1'b1;
        while (ok && done_lanes < lane_count) begin
            // lane 3 goes out first
            pos = 2'(lane_count - 1 - done_lanes);
            pop_lane(data, par, err, ok);
            if (ok) begin
                check_lane(sent.lanes[pos], ^sent.lanes[pos], data, par);
                if (err) begin
                    retries++;
                end else begin
                    got.lanes[pos] = data;
                    done_lanes++;
                end
            end
        end
        if (ok) begin
            check_word(sent, got);
            if (retries != exp_retries) begin
                error_count++;
                $display("a word needed %0d lane retries, %0d were expected",
                         retries, exp_retries);
            end
        end
    endtask

    task automatic check_tik_pulse(input int cycles);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!tik && waited < lane_wait_max) begin
            @(negedge clk);
            waited++;
        end
        if (!tik) begin
            error_count++;
            $display("tik never rose after the tik command");
            return;
        end
        for (int i = 0; i < cycles; i++) begin
            check_bit("tik", 1'b1, tik);
            check_bit("lane_valid", 1'b0, lane_valid);
            @(negedge clk);
        end
        check_bit("tik", 1'b0, tik);
    endtask

    task automatic check_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_bit("tik", 1'b0, tik);
            check_bit("lane_valid", 1'b0, lane_valid);
        end
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic test_reset_state();
        @(negedge clk);
        check_bit("lane_valid", 1'b0, lane_valid);
        check_bit("tik", 1'b0, tik);
        check_bit("lane_par", 1'b0, lane_par);
        check_bit("s_tready", 1'b1, s_tready);
    endtask

    task automatic test_data_words();
        for (int n = 0; n < 3; n++) begin
            send_word(data_word(n));
        end
        for (int n = 0; n < 3; n++) begin
            expect_word(data_word(n), 0);
        end
    endtask

    task automatic test_err_retry();
        // err on the second lane of the next word
        err_pres = pres_idx + 1;
        send_word(data_word(10));
        expect_word(data_word(10), 1);
        err_pres = -1;
    endtask

    task automatic test_tik_command();
        send_word(cmd_word(5, 1'b0));
        fork
            send_word(data_word(20));
            check_tik_pulse(5 + 1);
        join
        expect_word(data_word(20), 0);
    endtask

    task automatic test_end_command();
        send_word(cmd_word(7, 1'b1));
        // gap of length+1 followed by fifo read, decode and idle
        fork
            send_word(data_word(30));
            check_quiet(7 + 1 + 3);
        join
        expect_word(data_word(30), 0);
    endtask

    task automatic test_back_pressure();
        link_word_u sent [$];
        int         accepted;
        bit         stalled;
        accepted   = 0;
        stalled    = 1'b0;
        ready_hold = 1'b1;
        @(posedge clk);
        s_tdata  <= data_word(40);
        s_tvalid <= 1'b1;
        while (!stalled && accepted < 40) begin
            @(negedge clk);
            if (!s_tready) begin
                stalled = 1'b1;
            end else begin
                @(posedge clk);
                sent.push_back(data_word(40 + accepted));
                accepted++;
                s_tdata <= data_word(40 + accepted);
            end
        end
        @(posedge clk);
        s_tvalid <= 1'b0;
        if (!stalled) begin
            error_count++;
            $display("s_tready stayed high while the chip held ready low");
        end else if (accepted > 17) begin
            error_count++;
            $display("%0d words accepted before s_tready fell, at most 17 fit", accepted);
        end
        // nothing drains while the chip holds ready low
        repeat (20) begin
            @(negedge clk);
            if (stalled) begin
                check_bit("s_tready", 1'b0, s_tready);
            end
        end
        @(posedge clk);
        ready_hold = 1'b0;
        foreach (sent[i]) begin
            expect_word(sent[i], 0);
        end
    endtask

    initial begin : main
        rst_n    = 1'b0;
        s_tvalid = 1'b0;
        s_tdata  = '0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_data_words();
        test_err_retry();
        test_tik_command();
        test_end_command();
        test_back_pressure();
        if (rec_rd != lane_q.size()) begin
            error_count++;
            $display("%0d lanes reached the chip that no test expected",
                     lane_q.size() - rec_rd);
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
link_pkg.sv
word_fifo.sv
tik_timer.sv
lane_serializer.sv
send_fsm.sv
chip_link_tx.sv
tb_chip_link_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the chip link transmit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_chip_link_tx -f project.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build returned an error"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" sim.log; then
    exit 0
fi
exit 1
